/* common/rob_pkg.sv */
// reorder buffer definitions
`default_nettype none

package rob_pkg;

	// --------------------
	// widths and sizes
	// --------------------

	// one data word on either stream
	localparam int DATA_WIDTH = 16;

	// buffer address, pointers carry one extra wrap bit
	localparam int PTR_WIDTH = 6;
	localparam int DEPTH = 1 << PTR_WIDTH;

	// words per block and the in-block index
	localparam int BLOCK_LEN = 8;
	localparam int IDX_WIDTH = 3;

	// --------------------
	// state encodings
	// --------------------

	// writer side
	typedef enum logic [1:0] {
		// waiting for room for a whole block
		WR_IDLE,
		// accepting indexed words
		WR_COLLECT,
		// single pointer step
		WR_COMMIT
	} wr_state_t;

	// reader side
	typedef enum logic [1:0] {
		// waiting for a complete block
		RD_IDLE,
		// issuing reads, presenting words
		RD_STREAM,
		// single read pointer step
		RD_RELEASE
	} rd_state_t;

endpackage

`default_nettype wire

/* fifo_ra/ram_dualport.sv */
// simple dual-port RAM
`timescale 1ns/1ps
`default_nettype none

module ram_dualport
	import rob_pkg::*;
(
	input  logic                  clk,

	// write port
	input  logic                  wr_en,
	input  logic [PTR_WIDTH-1:0]  wr_addr,
	input  logic [DATA_WIDTH-1:0] wr_data,

	// read port
	input  logic                  rd_en,
	input  logic [PTR_WIDTH-1:0]  rd_addr,
	output logic [DATA_WIDTH-1:0] rd_data
);

	// --------------------
	// storage
	// --------------------

	logic [DATA_WIDTH-1:0] mem [0:DEPTH-1];

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
	end

	// --------------------
	// read
	// --------------------

	// one cycle latency; output register only moves with rd_en,
	// so a stalled consumer keeps seeing the same word
	always_ff @(posedge clk) begin
		if (rd_en) begin
			rd_data <= mem[rd_addr];
		end
	end

endmodule

`default_nettype wire

/* fifo_ra/fifo_ra.sv */
// random access FIFO
`timescale 1ns/1ps
`default_nettype none

module fifo_ra
	import rob_pkg::*;
(
	input  logic                  clk,
	input  logic                  reset,

	// write side
	input  logic                  wr_en,
	input  logic [PTR_WIDTH-1:0]  wr_addr,
	input  logic [DATA_WIDTH-1:0] wr_data,
	output logic [PTR_WIDTH-1:0]  wr_ptr_addr,
	input  logic                  wr_ptr_update,
	input  logic [PTR_WIDTH-1:0]  wr_ptr_step,

	// read side
	input  logic                  rd_en,
	input  logic [PTR_WIDTH-1:0]  rd_addr,
	output logic [DATA_WIDTH-1:0] rd_data,
	output logic [PTR_WIDTH-1:0]  rd_ptr_addr,
	input  logic                  rd_ptr_update,
	input  logic [PTR_WIDTH-1:0]  rd_ptr_step,

	// status
	output logic                  full,
	output logic                  empty,
	output logic [PTR_WIDTH:0]    free_count,
	output logic [PTR_WIDTH:0]    data_count
);

	// --------------------
	// RAM
	// --------------------

	ram_dualport u_ram (
		.clk     (clk),
		.wr_en   (wr_en),
		.wr_addr (wr_addr),
		.wr_data (wr_data),
		.rd_en   (rd_en),
		.rd_addr (rd_addr),
		.rd_data (rd_data)
	);

	// --------------------
	// pointers
	// --------------------

	// extra msb tells full from empty
	logic [PTR_WIDTH:0] wptr;
	logic [PTR_WIDTH:0] rptr;
	logic [PTR_WIDTH:0] wptr_next;
	logic [PTR_WIDTH:0] rptr_next;

	always_comb begin
		wptr_next = wptr;
		rptr_next = rptr;
		if (wr_ptr_update) begin
			wptr_next = wptr + (PTR_WIDTH+1)'(wr_ptr_step);
		end
		if (rd_ptr_update) begin
			rptr_next = rptr + (PTR_WIDTH+1)'(rd_ptr_step);
		end
	end

	// flags and counts registered from the next pointers,
	// so they line up with the pointers themselves
	always_ff @(posedge clk) begin
		if (reset) begin
			wptr       <= '0;
			rptr       <= '0;
			full       <= 1'b1;
			empty      <= 1'b1;
			free_count <= '0;
			data_count <= '0;
		end else begin
			wptr       <= wptr_next;
			rptr       <= rptr_next;
			empty      <= (wptr_next == rptr_next);
			full       <= (wptr_next[PTR_WIDTH] != rptr_next[PTR_WIDTH]) &&
				(wptr_next[PTR_WIDTH-1:0] == rptr_next[PTR_WIDTH-1:0]);
			data_count <= wptr_next - rptr_next;
			free_count <= (rptr_next - wptr_next) + (PTR_WIDTH+1)'(DEPTH);
		end
	end

	assign wr_ptr_addr = wptr[PTR_WIDTH-1:0];
	assign rd_ptr_addr = rptr[PTR_WIDTH-1:0];

	// --------------------
	// checks
	// --------------------

	// the writer must have reserved room before it commits
	a_wr_step: assert property (@(posedge clk) disable iff (reset)
		wr_ptr_update |-> ((PTR_WIDTH+1)'(wr_ptr_step) <= free_count));

	// the reader releases only what was committed
	a_rd_step: assert property (@(posedge clk) disable iff (reset)
		rd_ptr_update |-> ((PTR_WIDTH+1)'(rd_ptr_step) <= data_count));

endmodule

`default_nettype wire

/* design/reorder_writer.sv */
// block reorder writer
`timescale 1ns/1ps
`default_nettype none

module reorder_writer
	import rob_pkg::*;
(
	input  logic                  clk,
	input  logic                  reset,

	// indexed input stream
	input  logic                  in_valid,
	output logic                  in_ready,
	input  logic [IDX_WIDTH-1:0]  in_index,
	input  logic [DATA_WIDTH-1:0] in_data,

	// FIFO status
	input  logic [PTR_WIDTH:0]    free_count,
	input  logic [PTR_WIDTH-1:0]  wr_ptr_addr,

	// FIFO write side
	output logic                  wr_en,
	output logic [PTR_WIDTH-1:0]  wr_addr,
	output logic [DATA_WIDTH-1:0] wr_data,
	output logic                  wr_ptr_update,
	output logic [PTR_WIDTH-1:0]  wr_ptr_step
);

	wr_state_t state;
	wr_state_t state_next;

	// one bit per index already stored in the open block
	logic [BLOCK_LEN-1:0] fill;
	logic [BLOCK_LEN-1:0] fill_next;
	logic                 accept;

	assign accept = in_valid && in_ready;
	assign fill_next = fill | (BLOCK_LEN'(1) << in_index);

	// --------------------
	// next state
	// --------------------

	always_comb begin
		state_next = state;
		case (state)
			WR_IDLE: begin
				if (free_count >= (PTR_WIDTH+1)'(BLOCK_LEN)) begin
					state_next = WR_COLLECT;
				end
			end
			WR_COLLECT: begin
				// duplicates just set a bit that is already set
				if (accept && (&fill_next)) begin
					state_next = WR_COMMIT;
				end
			end
			default: begin
				state_next = WR_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state    <= WR_IDLE;
			fill     <= '0;
			in_ready <= 1'b0;
		end else begin
			state    <= state_next;
			in_ready <= (state_next == WR_COLLECT);
			if (state == WR_COMMIT) begin
				fill <= '0;
			end else if (accept) begin
				fill <= fill_next;
			end
		end
	end

	// --------------------
	// FIFO side
	// --------------------

	// words land at their offset past the write pointer, wrapping
	assign wr_en   = accept;
	assign wr_addr = wr_ptr_addr + PTR_WIDTH'(in_index);
	assign wr_data = in_data;

	assign wr_ptr_update = (state == WR_COMMIT);
	assign wr_ptr_step   = PTR_WIDTH'(BLOCK_LEN);

	// an open block always has its room reserved behind the write pointer
	a_ready_room: assert property (@(posedge clk) disable iff (reset)
		in_ready |-> (free_count >= (PTR_WIDTH+1)'(BLOCK_LEN)));

endmodule

`default_nettype wire

/* design/block_reader.sv */
// in-order block reader
`timescale 1ns/1ps
`default_nettype none

module block_reader
	import rob_pkg::*;
(
	input  logic                  clk,
	input  logic                  reset,

	// FIFO status
	input  logic [PTR_WIDTH:0]    data_count,
	input  logic [PTR_WIDTH-1:0]  rd_ptr_addr,

	// FIFO read side
	output logic                  rd_en,
	output logic [PTR_WIDTH-1:0]  rd_addr,
	output logic                  rd_ptr_update,
	output logic [PTR_WIDTH-1:0]  rd_ptr_step,
	input  logic [DATA_WIDTH-1:0] rd_data,

	// output stream
	output logic                  out_valid,
	input  logic                  out_ready,
	output logic [DATA_WIDTH-1:0] out_data,
	output logic                  out_last
);

	rd_state_t state;
	rd_state_t state_next;

	// reads issued, 0 to BLOCK_LEN
	logic [IDX_WIDTH:0]   issue_cnt;
	// words taken by the consumer
	logic [IDX_WIDTH-1:0] deliv_cnt;

	logic can_advance;
	logic issue_done;
	logic take;
	logic take_last;

	// output slot is free or about to be emptied
	assign can_advance = !out_valid || out_ready;
	assign issue_done  = (issue_cnt == (IDX_WIDTH+1)'(BLOCK_LEN));
	assign take        = out_valid && out_ready;
	assign take_last   = take && (deliv_cnt == IDX_WIDTH'(BLOCK_LEN - 1));

	// --------------------
	// next state
	// --------------------

	always_comb begin
		state_next = state;
		case (state)
			RD_IDLE: begin
				if (data_count >= (PTR_WIDTH+1)'(BLOCK_LEN)) begin
					state_next = RD_STREAM;
				end
			end
			RD_STREAM: begin
				if (take_last) begin
					state_next = RD_RELEASE;
				end
			end
			default: begin
				state_next = RD_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state     <= RD_IDLE;
			issue_cnt <= '0;
			deliv_cnt <= '0;
			out_valid <= 1'b0;
			out_last  <= 1'b0;
		end else begin
			state <= state_next;
			if (state == RD_RELEASE) begin
				issue_cnt <= '0;
				deliv_cnt <= '0;
			end else begin
				if (rd_en) begin
					issue_cnt <= issue_cnt + 1'b1;
				end
				if (take) begin
					deliv_cnt <= deliv_cnt + 1'b1;
				end
			end
			// valid and last follow the read by one cycle, like the RAM data
			if (can_advance) begin
				out_valid <= rd_en;
				out_last  <= rd_en && (issue_cnt == (IDX_WIDTH+1)'(BLOCK_LEN - 1));
			end
		end
	end

	// --------------------
	// FIFO side
	// --------------------

	assign rd_en   = (state == RD_STREAM) && !issue_done && can_advance;
	assign rd_addr = rd_ptr_addr + PTR_WIDTH'(issue_cnt[IDX_WIDTH-1:0]);

	assign rd_ptr_update = (state == RD_RELEASE);
	assign rd_ptr_step   = PTR_WIDTH'(BLOCK_LEN);

	// RAM output register is the data path
	assign out_data = rd_data;

	// a stalled word stays put until it is taken
	a_out_hold: assert property (@(posedge clk) disable iff (reset)
		out_valid && !out_ready |=> out_valid && $stable(out_data) && $stable(out_last));

endmodule

`default_nettype wire

/* design/reorder_buffer_top.sv */
// reorder buffer top level
`timescale 1ns/1ps
`default_nettype none

module reorder_buffer_top
	import rob_pkg::*;
(
	input  logic                  clk,
	input  logic                  reset,

	// indexed input stream
	input  logic                  in_valid,
	output logic                  in_ready,
	input  logic [IDX_WIDTH-1:0]  in_index,
	input  logic [DATA_WIDTH-1:0] in_data,

	// ordered output stream
	output logic                  out_valid,
	input  logic                  out_ready,
	output logic [DATA_WIDTH-1:0] out_data,
	output logic                  out_last,

	// buffer status
	output logic                  buf_empty,
	output logic                  buf_full
);

	// --------------------
	// writer to FIFO
	// --------------------

	logic                  wr_en;
	logic [PTR_WIDTH-1:0]  wr_addr;
	logic [DATA_WIDTH-1:0] wr_data;
	logic [PTR_WIDTH-1:0]  wr_ptr_addr;
	logic                  wr_ptr_update;
	logic [PTR_WIDTH-1:0]  wr_ptr_step;
	logic [PTR_WIDTH:0]    free_count;

	// --------------------
	// FIFO to reader
	// --------------------

	logic                  rd_en;
	logic [PTR_WIDTH-1:0]  rd_addr;
	logic [DATA_WIDTH-1:0] rd_data;
	logic [PTR_WIDTH-1:0]  rd_ptr_addr;
	logic                  rd_ptr_update;
	logic [PTR_WIDTH-1:0]  rd_ptr_step;
	logic [PTR_WIDTH:0]    data_count;

	reorder_writer u_writer (
		.clk           (clk),
		.reset         (reset),
		.in_valid      (in_valid),
		.in_ready      (in_ready),
		.in_index      (in_index),
		.in_data       (in_data),
		.free_count    (free_count),
		.wr_ptr_addr   (wr_ptr_addr),
		.wr_en         (wr_en),
		.wr_addr       (wr_addr),
		.wr_data       (wr_data),
		.wr_ptr_update (wr_ptr_update),
		.wr_ptr_step   (wr_ptr_step)
	);

	fifo_ra u_fifo (
		.clk           (clk),
		.reset         (reset),
		.wr_en         (wr_en),
		.wr_addr       (wr_addr),
		.wr_data       (wr_data),
		.wr_ptr_addr   (wr_ptr_addr),
		.wr_ptr_update (wr_ptr_update),
		.wr_ptr_step   (wr_ptr_step),
		.rd_en         (rd_en),
		.rd_addr       (rd_addr),
		.rd_data       (rd_data),
		.rd_ptr_addr   (rd_ptr_addr),
		.rd_ptr_update (rd_ptr_update),
		.rd_ptr_step   (rd_ptr_step),
		.full          (buf_full),
		.empty         (buf_empty),
		.free_count    (free_count),
		.data_count    (data_count)
	);

	block_reader u_reader (
		.clk           (clk),
		.reset         (reset),
		.data_count    (data_count),
		.rd_ptr_addr   (rd_ptr_addr),
		.rd_en         (rd_en),
		.rd_addr       (rd_addr),
		.rd_ptr_update (rd_ptr_update),
		.rd_ptr_step   (rd_ptr_step),
		.rd_data       (rd_data),
		.out_valid     (out_valid),
		.out_ready     (out_ready),
		.out_data      (out_data),
		.out_last      (out_last)
	);

endmodule

`default_nettype wire

/* verif/tb_reorder_buffer.sv */
// reorder buffer testbench
`timescale 1ns/1ps
`default_nettype none

module tb_reorder_buffer
	import rob_pkg::*;
();

	localparam int TIMEOUT = 500;

	logic                  clk;
	logic                  reset;
	logic                  in_valid;
	logic                  in_ready;
	logic [IDX_WIDTH-1:0]  in_index;
	logic [DATA_WIDTH-1:0] in_data;
	logic                  out_valid;
	logic                  out_ready;
	logic [DATA_WIDTH-1:0] out_data;
	logic                  out_last;
	logic                  buf_empty;
	logic                  buf_full;

	integer seed;

	// words of the next block in send order, one spare slot for a duplicate
	logic [IDX_WIDTH-1:0]  blk_idx [0:BLOCK_LEN];
	logic [DATA_WIDTH-1:0] blk_dat [0:BLOCK_LEN];
	// expected output words, oldest first
	logic [DATA_WIDTH-1:0] exp_q [$];

	reorder_buffer_top UUT (
		.clk       (clk),
		.reset     (reset),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.in_index  (in_index),
		.in_data   (in_data),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out_data  (out_data),
		.out_last  (out_last),
		.buf_empty (buf_empty),
		.buf_full  (buf_full)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// --------------------
	// helpers
	// --------------------

	task automatic check(input logic [31:0] actual, input logic [31:0] expected,
		input string msg);
		if (actual !== expected) begin
			$display("mismatch at %0t ns: %s, got %0h expected %0h",
				$time, msg, actual, expected);
			$display("Result: FAILED");
			$fatal(1, "stopping at first error");
		end
	endtask

	task automatic report_stall(input string what);
		$display("timeout at %0t ns: %s", $time, what);
		$display("Result: FAILED");
		$fatal(1, "stopping on timeout");
	endtask

	// all helpers start and end 1 ns after a rising edge
	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic fill_block(input bit shuffle);
		int j;
		logic [IDX_WIDTH-1:0] tmp;
		for (int i = 0; i < BLOCK_LEN; i++) begin
			blk_idx[i] = IDX_WIDTH'(i);
			blk_dat[i] = DATA_WIDTH'($random(seed));
		end
		// fisher-yates over the indices
		if (shuffle) begin
			for (int i = BLOCK_LEN - 1; i > 0; i--) begin
				j = $unsigned($random(seed)) % (i + 1);
				tmp = blk_idx[i];
				blk_idx[i] = blk_idx[j];
				blk_idx[j] = tmp;
			end
		end
	endtask

	task automatic send_word(input logic [IDX_WIDTH-1:0] idx, input logic [DATA_WIDTH-1:0] dat);
		int waited;
		waited = 0;
		in_valid = 1'b1;
		in_index = idx;
		in_data  = dat;
		while (!in_ready) begin
			idle_cycles(1);
			waited++;
			if (waited > TIMEOUT) begin
				report_stall("input stream never became ready");
			end
		end
		// ready seen before the edge, so this edge takes the word
		idle_cycles(1);
		in_valid = 1'b0;
	endtask

	// later words at the same index replace earlier ones
	task automatic expect_block(input int n);
		logic [DATA_WIDTH-1:0] blk [0:BLOCK_LEN-1];
		for (int i = 0; i < n; i++) begin
			blk[blk_idx[i]] = blk_dat[i];
		end
		for (int k = 0; k < BLOCK_LEN; k++) begin
			exp_q.push_back(blk[k]);
		end
	endtask

	task automatic send_block(input int n);
		for (int i = 0; i < n; i++) begin
			send_word(blk_idx[i], blk_dat[i]);
		end
		expect_block(n);
	endtask

	task automatic recv_block(input bit rand_ready);
		int got;
		int idle;
		logic [DATA_WIDTH-1:0] want;
		got = 0;
		idle = 0;
		while (got < BLOCK_LEN) begin
			if (rand_ready) begin
				out_ready = ($random(seed) & 1) != 0;
			end else begin
				out_ready = 1'b1;
			end
			if (out_valid && out_ready) begin
				check(32'(exp_q.size() > 0), 32'd1, "output word with no block pending");
				want = exp_q.pop_front();
				check(out_data, want, $sformatf("data of word %0d", got));
				check(out_last, got == BLOCK_LEN - 1, $sformatf("last flag of word %0d", got));
				got++;
				idle = 0;
			end
			idle_cycles(1);
			idle++;
			if (idle > TIMEOUT) begin
				report_stall("output stream stopped inside a block");
			end
		end
		out_ready = 1'b0;
	endtask

	task automatic wait_status(input bit want_full);
		int waited;
		waited = 0;
		while (want_full ? !buf_full : !buf_empty) begin
			idle_cycles(1);
			waited++;
			if (waited > TIMEOUT) begin
				report_stall(want_full ? "buffer never reported full" :
					"buffer never reported empty");
			end
		end
	endtask

	// --------------------
	// tests
	// --------------------

	initial begin
		seed        = 32'h1184_e2e7;
		reset       = 1'b1;
		in_valid    = 1'b0;
		in_index    = '0;
		in_data     = '0;
		out_ready   = 1'b0;
		repeat (2) @(posedge clk);
		#1;
		reset = 1'b0;

		// in index order
		fill_block(1'b0);
		send_block(BLOCK_LEN);
		recv_block(1'b0);

		// shuffled indices
		fill_block(1'b1);
		send_block(BLOCK_LEN);
		recv_block(1'b0);

		// several blocks, consumer stalls at random
		for (int b = 0; b < 4; b++) begin
			fill_block(1'b1);
			send_block(BLOCK_LEN);
		end
		for (int b = 0; b < 4; b++) begin
			recv_block(1'b1);
		end

		// eight blocks with no consumer fill all 64 entries
		for (int b = 0; b < 8; b++) begin
			fill_block(1'b1);
			send_block(BLOCK_LEN);
		end
		wait_status(1'b1);
		fill_block(1'b1);
		in_valid = 1'b1;
		in_index = blk_idx[0];
		in_data  = blk_dat[0];
		for (int c = 0; c < 20; c++) begin
			check(in_ready, 1'b0, "in_ready while buffer full");
			idle_cycles(1);
		end
		recv_block(1'b0);
		send_block(BLOCK_LEN);
		for (int b = 0; b < 8; b++) begin
			recv_block(1'b1);
		end

		// repeat the first index as third word with new data
		fill_block(1'b1);
		for (int i = BLOCK_LEN; i > 2; i--) begin
			blk_idx[i] = blk_idx[i-1];
			blk_dat[i] = blk_dat[i-1];
		end
		blk_idx[2] = blk_idx[0];
		blk_dat[2] = DATA_WIDTH'($random(seed));
		for (int i = 0; i < BLOCK_LEN; i++) begin
			send_word(blk_idx[i], blk_dat[i]);
		end
		// right after the eighth word, a commit would already have dropped ready
		check(in_ready, 1'b1, "writer still collecting with one index missing");
		idle_cycles(4);
		check(out_valid, 1'b0, "output before block complete");
		send_word(blk_idx[BLOCK_LEN], blk_dat[BLOCK_LEN]);
		expect_block(BLOCK_LEN + 1);
		recv_block(1'b0);

		// drained
		wait_status(1'b0);
		check(out_valid, 1'b0, "out_valid after drain");
		check(exp_q.size(), 0, "expected words left over");

		$display("Result: PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* sources.f */
common/rob_pkg.sv
fifo_ra/ram_dualport.sv
fifo_ra/fifo_ra.sv
design/reorder_writer.sv
design/block_reader.sv
design/reorder_buffer_top.sv
verif/tb_reorder_buffer.sv
